//--- tge_params_pkg.sv
package tge_params_pkg;

  // Stretch counter width
  // A stretch lasts 2**(LED_WIDTH-1) cycles
  localparam int LED_WIDTH = 8;

  // Activity indicators
  localparam int NUM_LEDS = 3;

  // Positions in the trigger and stretch vectors
  localparam int LED_UP_IDX = 0;
  localparam int LED_RX_IDX = 1;
  localparam int LED_TX_IDX = 2;

  // XAUI status byte
  localparam int XAUI_STATUS_W = 8;

  // Lane sync bits of the status byte
  localparam int LINK_UP_LSB = 2;
  localparam int LINK_UP_MSB = 6;
  localparam int LINK_UP_W   = LINK_UP_MSB - LINK_UP_LSB + 1;

  // Link is up only when every lane reports sync
  localparam logic [LINK_UP_W-1:0] LINK_UP_PATTERN = {LINK_UP_W{1'b1}};

endpackage

//--- tge_types_pkg.sv
package tge_types_pkg;

  // Stretcher countdown
  typedef logic [tge_params_pkg::LED_WIDTH-1:0] stretch_cnt_t;

  // One bit per indicator at the LED_*_IDX positions
  typedef logic [tge_params_pkg::NUM_LEDS-1:0] led_vec_t;

  // Raw status byte from the XAUI core
  typedef logic [tge_params_pkg::XAUI_STATUS_W-1:0] xaui_status_t;

  // MAC event strobes and PHY status in 10 bits
  typedef struct packed {
    logic         rx_good_frame;
    logic         tx_start;
    xaui_status_t xaui_status;
  } mac_events_t;

  // Registered LED outputs
  typedef struct packed {
    logic up;
    logic rx;
    logic tx;
  } led_state_t;

  // Control side of the soft reset handshake
  typedef enum logic [1:0] {
    SWR_IDLE,
    SWR_WAIT_ACK,
    SWR_WAIT_RELEASE
  } swr_state_t;

  // MAC side of the soft reset handshake
  typedef enum logic {
    MACR_IDLE,
    MACR_HELD
  } macr_state_t;

endpackage

//--- tge_event_trig.sv
`timescale 1ns/1ns

module tge_event_trig (
  input  logic                       clk,
  input  logic                       mac_resetRR,
  input  tge_types_pkg::mac_events_t events,
  output tge_types_pkg::led_vec_t    trig
);

  logic link_down;

  // Down whenever any lane has lost sync
  assign link_down =
    events.xaui_status[tge_params_pkg::LINK_UP_MSB:tge_params_pkg::LINK_UP_LSB] !=
    tge_params_pkg::LINK_UP_PATTERN;

  // One trigger register per indicator
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      trig <= '0;
    end else begin
      trig[tge_params_pkg::LED_UP_IDX] <= link_down;
      trig[tge_params_pkg::LED_RX_IDX] <= events.rx_good_frame;
      trig[tge_params_pkg::LED_TX_IDX] <= events.tx_start;
    end
  end

endmodule

//--- tge_led_stretch.sv
`timescale 1ns/1ns

module tge_led_stretch (
  input  logic clk,
  input  logic mac_resetRR,
  input  logic trig,
  output logic stretch_msb
);

  tge_types_pkg::stretch_cnt_t cnt;
  logic                        cnt_msb;

  assign cnt_msb = cnt[tge_params_pkg::LED_WIDTH-1];

  // Reload on every trigger, so a burst keeps the LED lit
  // Countdown stops once the top bit clears
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      cnt <= '0;
    end else if (trig) begin
      cnt <= '1;
    end else if (cnt_msb) begin
      cnt <= cnt - tge_types_pkg::stretch_cnt_t'(1);
    end
  end

  // Top bit high for half the counter range after a load
  assign stretch_msb = cnt_msb;

endmodule

//--- tge_led_drive.sv
`timescale 1ns/1ns

module tge_led_drive (
  input  logic                      clk,
  input  logic                      mac_resetRR,
  input  tge_types_pkg::led_vec_t   stretch_msb,
  output tge_types_pkg::led_state_t leds
);

  tge_types_pkg::led_state_t leds_next;

  // The up stretcher counts link-down time
  always_comb begin
    leds_next.up = ~stretch_msb[tge_params_pkg::LED_UP_IDX];
    leds_next.rx = stretch_msb[tge_params_pkg::LED_RX_IDX];
    leds_next.tx = stretch_msb[tge_params_pkg::LED_TX_IDX];
  end

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      leds <= '0;
    end else begin
      leds <= leds_next;
    end
  end

endmodule

//--- tge_soft_reset.sv
`timescale 1ns/1ns

module tge_soft_reset (
  input  logic clk,
  input  logic mac_resetRR,
  input  logic rst,
  input  logic soft_reset,
  output logic soft_reset_ack,
  output logic app_reset
);

  tge_types_pkg::swr_state_t  swr_state;
  tge_types_pkg::macr_state_t macr_state;

  logic mac_req;
  logic mac_held;
  logic usr_rst;

  // Control side
  // Strobes arriving mid-handshake are dropped
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      swr_state <= tge_types_pkg::SWR_IDLE;
    end else begin
      case (swr_state)
        tge_types_pkg::SWR_IDLE: begin
          if (soft_reset) begin
            swr_state <= tge_types_pkg::SWR_WAIT_ACK;
          end
        end
        tge_types_pkg::SWR_WAIT_ACK: begin
          if (mac_held) begin
            swr_state <= tge_types_pkg::SWR_WAIT_RELEASE;
          end
        end
        tge_types_pkg::SWR_WAIT_RELEASE: begin
          if (!mac_held) begin
            swr_state <= tge_types_pkg::SWR_IDLE;
          end
        end
        default: begin
          swr_state <= tge_types_pkg::SWR_IDLE;
        end
      endcase
    end
  end

  assign mac_req        = swr_state == tge_types_pkg::SWR_WAIT_ACK;
  assign soft_reset_ack = mac_req && mac_held;

  // MAC side holds while the request is up
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      macr_state <= tge_types_pkg::MACR_IDLE;
    end else begin
      case (macr_state)
        tge_types_pkg::MACR_IDLE: begin
          if (mac_req) begin
            macr_state <= tge_types_pkg::MACR_HELD;
          end
        end
        tge_types_pkg::MACR_HELD: begin
          if (!mac_req) begin
            macr_state <= tge_types_pkg::MACR_IDLE;
          end
        end
        default: begin
          macr_state <= tge_types_pkg::MACR_IDLE;
        end
      endcase
    end
  end

  assign mac_held = macr_state == tge_types_pkg::MACR_HELD;

  // One cycle between request drop and return to idle
  assign usr_rst = mac_held && !mac_req;

  always_ff @(posedge clk) begin
    app_reset <= usr_rst || rst;
  end

endmodule

//--- tge_status_top.sv
`timescale 1ns/1ns

module tge_status_top (
  input  logic                       clk,
  input  logic                       mac_resetRR,
  input  logic                       rst,
  input  tge_types_pkg::mac_events_t events,
  input  logic                       soft_reset,
  output logic                       soft_reset_ack,
  output logic                       app_reset,
  output tge_types_pkg::led_state_t  leds
);

  tge_types_pkg::led_vec_t trig;
  tge_types_pkg::led_vec_t stretch_msb;

  tge_event_trig i_event_trig (
    .clk         (clk),
    .mac_resetRR (mac_resetRR),
    .events      (events),
    .trig        (trig)
  );

  // One stretcher per indicator
  for (genvar i = 0; i < tge_params_pkg::NUM_LEDS; i++) begin : g_led
    tge_led_stretch i_led_stretch (
      .clk         (clk),
      .mac_resetRR (mac_resetRR),
      .trig        (trig[i]),
      .stretch_msb (stretch_msb[i])
    );
  end

  tge_led_drive i_led_drive (
    .clk         (clk),
    .mac_resetRR (mac_resetRR),
    .stretch_msb (stretch_msb),
    .leds        (leds)
  );

  tge_soft_reset i_soft_reset (
    .clk            (clk),
    .mac_resetRR    (mac_resetRR),
    .rst            (rst),
    .soft_reset     (soft_reset),
    .soft_reset_ack (soft_reset_ack),
    .app_reset      (app_reset)
  );

endmodule

//--- tb_tge_status.sv
`timescale 1ns/1ns

module tb_tge_status;

  localparam int MAX_TESTS  = 32;
  localparam int FIELDS     = 7;
  localparam int MAX_CYCLES = 4096;
  localparam int STRETCH    = 1 << (tge_params_pkg::LED_WIDTH - 1);
  // Drive edge to LED register edge
  localparam int LED_DELAY  = 3;
  localparam tge_types_pkg::xaui_status_t STATUS_UP = 8'hff;

  logic                       clk;
  logic                       mac_resetRR;
  logic                       rst;
  logic                       soft_reset;
  tge_types_pkg::mac_events_t events;
  logic                       soft_reset_ack;
  logic                       app_reset;
  tge_types_pkg::led_state_t  leds;

  // Seven fields per test in vector file order
  logic [15:0] vec_mem [0:MAX_TESTS*FIELDS-1];
  logic        vectors_loaded;
  int          num_tests;

  // Stimulus of the running test with one entry per cycle
  tge_types_pkg::xaui_status_t stat_hist [0:MAX_CYCLES-1];
  logic rx_hist  [0:MAX_CYCLES-1];
  logic tx_hist  [0:MAX_CYCLES-1];
  logic swr_hist [0:MAX_CYCLES-1];
  logic acc_hist [0:MAX_CYCLES-1];
  logic rst_hist [0:MAX_CYCLES-1];

  logic [31:0] rng_state;
  int          up_ready;
  int          test_errors;
  int          pass_count;
  int          fail_count;

  tge_status_top i_dut (
    .clk            (clk),
    .mac_resetRR    (mac_resetRR),
    .rst            (rst),
    .events         (events),
    .soft_reset     (soft_reset),
    .soft_reset_ack (soft_reset_ack),
    .app_reset      (app_reset),
    .leds           (leds)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Gap between train strobes of 1 to 127 cycles
  function automatic int next_gap();
    rng_state = xorshift32(rng_state);
    return int'(rng_state % 32'd127) + 1;
  endfunction

  function automatic logic link_is_down(input tge_types_pkg::xaui_status_t status);
    return !(&status[tge_params_pkg::LINK_UP_MSB:tge_params_pkg::LINK_UP_LSB]);
  endfunction

  // A trigger lights its LED from 3 cycles later for 128 cycles
  function automatic logic stretch_active(input int c, input int sel);
    logic hit;
    hit = 1'b0;
    for (int s = c - LED_DELAY - STRETCH + 1; s <= c - LED_DELAY; s++) begin
      if (s >= 0) begin
        case (sel)
          0: hit = hit | link_is_down(stat_hist[s]);
          1: hit = hit | rx_hist[s];
          default: hit = hit | tx_hist[s];
        endcase
      end
    end
    return hit;
  endfunction

  // Bits are up, rx, tx, ack, app_reset
  function automatic logic [4:0] expected_outputs(input int c);
    logic [4:0] exp_val;
    exp_val = '0;
    exp_val[4] = (c >= up_ready) && !stretch_active(c, 0);
    exp_val[3] = stretch_active(c, 1);
    exp_val[2] = stretch_active(c, 2);
    if (c >= 2) begin
      exp_val[1] = acc_hist[c-2];
    end
    if (c >= 4) begin
      exp_val[0] = acc_hist[c-4];
    end
    if (c >= 1) begin
      exp_val[0] = exp_val[0] | rst_hist[c-1];
    end
    return exp_val;
  endfunction

  task automatic check_bit(input string name, input logic exp_bit, input logic act_bit);
    if (act_bit !== exp_bit) begin
      $display("ERROR t=%0t %s expected %0b actual %0b", $time, name, exp_bit, act_bit);
      test_errors++;
    end
  endtask

  task automatic check_outputs(input logic [4:0] exp_val);
    check_bit("leds.up", exp_val[4], leds.up);
    check_bit("leds.rx", exp_val[3], leds.rx);
    check_bit("leds.tx", exp_val[2], leds.tx);
    check_bit("soft_reset_ack", exp_val[1], soft_reset_ack);
    check_bit("app_reset", exp_val[0], app_reset);
  endtask

  // Leaves reset asserted for the next drive edge to release
  task automatic apply_reset(input tge_types_pkg::xaui_status_t status);
    @(posedge clk);
    mac_resetRR          <= 1'b1;
    rst                  <= 1'b0;
    soft_reset           <= 1'b0;
    events.rx_good_frame <= 1'b0;
    events.tx_start      <= 1'b0;
    events.xaui_status   <= status;
    repeat (15) @(posedge clk);
  endtask

  task automatic run_test(input int t);
    int base;
    int kind;
    int gap;
    int offset;
    int len;
    int c;
    tge_types_pkg::xaui_status_t status;
    logic [1:0] pattern;
    logic [4:0] exp_vec;
    base        = t * FIELDS;
    kind        = int'(vec_mem[base+1]);
    status      = vec_mem[base+2][7:0];
    pattern     = vec_mem[base+3][1:0];
    gap         = int'(vec_mem[base+4]);
    offset      = int'(vec_mem[base+5]);
    exp_vec     = vec_mem[base+6][4:0];
    len         = gap + offset + 140;
    test_errors = 0;
    up_ready    = 0;
    if (len > MAX_CYCLES) begin
      $display("Test %0d is too long for the stimulus buffer", int'(vec_mem[base]));
      test_errors++;
      len = MAX_CYCLES;
    end
    for (int i = 0; i < MAX_CYCLES; i++) begin
      stat_hist[i] = (kind == 1) ? status : STATUS_UP;
      rx_hist[i]   = 1'b0;
      tx_hist[i]   = 1'b0;
      swr_hist[i]  = 1'b0;
      rst_hist[i]  = 1'b0;
    end
    case (kind)
      1: up_ready = 1;
      2: begin
        rx_hist[0] = pattern[0];
        tx_hist[0] = pattern[1];
      end
      3: begin
        c = 0;
        while (c <= gap) begin
          rx_hist[c] = pattern[0];
          tx_hist[c] = pattern[1];
          c += next_gap();
        end
      end
      4: for (int i = 0; i < gap; i++) stat_hist[i] = status;
      5: begin
        swr_hist[0]   = 1'b1;
        swr_hist[gap] = 1'b1;
      end
      6: for (int i = 0; i < gap; i++) rst_hist[i] = 1'b1;
      default: begin
        $display("Test %0d has an unknown kind code %0d", int'(vec_mem[base]), kind);
        test_errors++;
      end
    endcase
    // Handshake is busy for four cycles after an accepted strobe
    for (int i = 0; i < len; i++) begin
      acc_hist[i] = swr_hist[i];
      for (int j = i - 4; j < i; j++) begin
        if (j >= 0) begin
          if (acc_hist[j]) begin
            acc_hist[i] = 1'b0;
          end
        end
      end
    end
    if (kind == 1) begin
      apply_reset(status);
    end
    for (int cyc = 0; cyc < len; cyc++) begin
      @(posedge clk);
      mac_resetRR          <= 1'b0;
      rst                  <= rst_hist[cyc];
      soft_reset           <= swr_hist[cyc];
      events.rx_good_frame <= rx_hist[cyc];
      events.tx_start      <= tx_hist[cyc];
      events.xaui_status   <= stat_hist[cyc];
      @(negedge clk);
      check_outputs(expected_outputs(cyc));
      if (cyc == offset) begin
        check_outputs(exp_vec);
      end
    end
    if (test_errors == 0) begin
      pass_count++;
      $display("test %0d kind %0d ok over %0d cycles", int'(vec_mem[base]), kind, len);
    end else begin
      fail_count++;
      $display("test %0d kind %0d FAILED with %0d mismatches", int'(vec_mem[base]), kind,
               test_errors);
    end
  endtask

  initial begin : main
    clk            = 1'b0;
    vectors_loaded = 1'b0;
    mac_resetRR    <= 1'b1;
    rst            <= 1'b0;
    soft_reset     <= 1'b0;
    events         <= '{rx_good_frame: 1'b0, tx_start: 1'b0, xaui_status: STATUS_UP};
    rng_state      = 32'd59188;
    pass_count     = 0;
    fail_count     = 0;
    for (int i = 0; i < MAX_TESTS * FIELDS; i++) begin
      vec_mem[i] = '0;
    end
    $readmemh("tge_status_vectors.txt", vec_mem);
    // Kind code 0 ends the list
    num_tests = 0;
    while (num_tests < MAX_TESTS && vec_mem[num_tests*FIELDS+1] != 16'h0) begin
      num_tests++;
    end
    vectors_loaded = 1'b1;
    apply_reset(STATUS_UP);
    @(posedge clk);
    mac_resetRR <= 1'b0;
    repeat (4) @(posedge clk);
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && num_tests > 0) begin
      $display("Testbench passed");
    end else begin
      if (num_tests == 0) begin
        $display("No test vectors were read from the vector file");
      end
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    int timeout_cycles;
    wait (vectors_loaded === 1'b1);
    timeout_cycles = 300;
    for (int t = 0; t < num_tests; t++) begin
      timeout_cycles += int'(vec_mem[t*FIELDS+4]) + int'(vec_mem[t*FIELDS+5]) + 300;
    end
    repeat (timeout_cycles) @(posedge clk);
    $display("Simulation did not finish within %0d cycles", timeout_cycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- tge_status_vectors.txt
// test kind status events gap check expected, all hex
// kind 1 reset, 2 single strobe, 3 strobe train, 4 status glitch, 5 soft reset, 6 rst hold
// events bit 0 rx_good_frame, bit 1 tx_start
// gap is the train span, glitch or hold length, or the second soft reset distance
// expected bits at the check cycle are up rx tx ack app_reset
01 1 ff 0 000 1 10
02 2 ff 1 000 3 18
03 2 ff 2 000 3 14
04 2 ff 3 000 3 1c
05 3 ff 1 180 3 18
06 3 ff 2 200 3 14
07 4 fb 0 001 3 00
08 4 f7 0 001 3 00
09 4 ef 0 001 3 00
0a 4 df 0 001 3 00
0b 4 bf 0 001 3 00
0c 4 7c 0 001 3 10
0d 4 f7 0 004 3 00
0e 5 ff 0 002 4 11
0f 6 ff 0 005 1 11
10 1 7f 0 000 1 10

//--- build.f
tge_params_pkg.sv
tge_types_pkg.sv
tge_event_trig.sv
tge_led_stretch.sv
tge_led_drive.sv
tge_soft_reset.sv
tge_status_top.sv
tb_tge_status.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the status block testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing -j 0 --top-module tb_tge_status -Mdir obj_dir -f build.f; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_tge_status > "$log" 2>&1
sim_status=$?
cat "$log"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Testbench failed" "$log"; then
  exit 1
fi
exit 0
